//--- vga_spi_top.f
+incdir+.
vga_spi_pkg.sv
spi_byte_receiver.sv
pixel_command_decoder.sv
frame_ram.sv
frame_double_buffer.sv
vga_timing.sv
pixel_scanout.sv
vga_spi_top.sv
tb_vga_spi.sv

//--- run_sim.sh
#!/bin/sh
# Build the frame grabber testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vga_spi \
    -f vga_spi_top.f --Mdir obj_dir -o sim_vga_spi

out=$(./obj_dir/sim_vga_spi)
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -qx "STATUS: PASS"

//--- tb_vga_spi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_spi;

    // Display timing in pixel ticks
    localparam int PIX_DIV      = 2;
    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int H_SYNC_LEN   = 96;
    localparam int V_SYNC_LEN   = 2;
    localparam int H_ACT_START  = 144;
    localparam int H_ACT_END    = 784;
    localparam int V_ACT_START  = 35;
    localparam int V_ACT_END    = 515;
    localparam int RES_X        = 320;
    localparam int FB_DEPTH     = 76800;
    localparam int LINE_CYCLES  = H_TOTAL * PIX_DIV;
    localparam int FRAME_CYCLES = LINE_CYCLES * V_TOTAL;
    // A swap lands on the next frame start, two spare lines of slack
    localparam int SWAP_WAIT    = FRAME_CYCLES + 2 * LINE_CYCLES;
    // About nine and a half frames
    localparam int CYCLE_LIMIT  = 8_000_000;
    localparam logic [31:0] SEED     = 32'd54839;
    localparam logic [6:0]  OP_ALIGN = 7'h00;
    localparam logic [6:0]  OP_SWAP  = 7'h01;

    logic       clk;
    logic       rst;
    logic       sclk;
    logic       cs_n;
    logic       mosi;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       h_sync;
    logic       v_sync;
    logic       swap_done;

    // Shadow frame store, bit 7 set marks a byte never written
    logic [7:0]  model [0:1][0:FB_DEPTH-1];
    logic        model_sel;
    logic [16:0] model_addr;
    logic [31:0] rng;
    logic        v_prev;
    int          errors;
    int          cycle_count;

    vga_spi_top dut0 (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .h_sync(h_sync), .v_sync(v_sync), .swap_done(swap_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Previous v_sync, for spotting the falling edge
    always @(posedge clk) begin
        v_prev <= v_sync;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ==================================================
    // SPI master
    // ==================================================

    // Mode 0, MSB first, four clk per sclk phase
    task automatic spi_send(input logic [7:0] value, input int nbits);
        logic [7:0] bits;
        bits = value;
        @(posedge clk);
        cs_n <= 1'b0;
        repeat (nbits) begin
            mosi <= bits[7];
            bits = bits << 1;
            repeat (4) @(posedge clk);
            sclk <= 1'b1;
            repeat (4) @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic send_pixel(input logic [7:0] value);
        spi_send(value, 8);
        model[model_sel][model_addr] = value;
        model_addr = (model_addr == 17'(FB_DEPTH - 1)) ? '0 : model_addr + 1'b1;
    endtask

    task automatic send_random_pixels(input int count);
        repeat (count) begin
            rng = xorshift32(rng);
            send_pixel({2'b00, rng[5:0]});
        end
    endtask

    // Every opcode except swap realigns the write address
    task automatic send_command(input logic [6:0] op);
        spi_send({1'b1, op}, 8);
        if (op != OP_SWAP) begin
            model_addr = '0;
        end
    endtask

    // Returns on the swap_done cycle so the next frame top is not missed
    task automatic wait_swap(input string name, input logic expect_swap);
        int   waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < SWAP_WAIT) begin
            @(posedge clk);
            waited = waited + 1;
            seen = swap_done;
        end
        if (seen) begin
            model_sel = ~model_sel;
        end
        if (seen != expect_swap) begin
            errors = errors + 1;
            if (expect_swap) begin
                $display("%s: swap_done did not arrive within one frame", name);
            end else begin
                $display("%s: swap_done arrived although the swap was cancelled", name);
            end
        end
    endtask

    // ==================================================
    // VGA sampler, one whole frame from the v_sync fall
    // ==================================================
    task automatic scan_frame(input string name);
        int          h;
        logic [16:0] addr;
        logic [7:0]  px;
        logic [11:0] exp_rgb;
        logic [1:0]  exp_sync;
        logic        known;
        @(posedge clk);
        while (!(v_prev && !v_sync)) begin
            @(posedge clk);
        end
        for (int line = 0; line < V_TOTAL; line++) begin
            for (int pos = 0; pos < LINE_CYCLES; pos++) begin
                if (line != 0 || pos != 0) begin
                    @(posedge clk);
                end
                h = pos / PIX_DIV;
                exp_sync = {pos >= H_SYNC_LEN * PIX_DIV, line >= V_SYNC_LEN};
                exp_rgb = '0;
                known = 1'b1;
                if (h >= H_ACT_START && h < H_ACT_END &&
                    line >= V_ACT_START && line < V_ACT_END) begin
                    // Each stored pixel covers 2x2 screen pixels
                    addr = 17'((h - H_ACT_START) / 2 + ((line - V_ACT_START) / 2) * RES_X);
                    px = model[~model_sel][addr];
                    known = ~px[7];
                    exp_rgb = {px[5:4], 2'b00, px[3:2], 2'b00, px[1:0], 2'b00};
                end
                if ({h_sync, v_sync} !== exp_sync) begin
                    errors = errors + 1;
                    $display("** Error %s: syncs at line %0d cycle %0d expected %b actual %b",
                             name, line, pos, exp_sync, {h_sync, v_sync});
                end
                if (known && {vga_r, vga_g, vga_b} !== exp_rgb) begin
                    errors = errors + 1;
                    $display("** Error %s: rgb at line %0d tick %0d expected %h actual %h",
                             name, line, h, exp_rgb, {vga_r, vga_g, vga_b});
                end
            end
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic swap_and_show();
        send_random_pixels(400);
        send_command(OP_SWAP);
        wait_swap("swap_show", 1'b1);
        scan_frame("swap_show");
    endtask

    // Back bank traffic during a frame must stay off screen
    task automatic hold_back_buffer();
        fork
            scan_frame("back_hold");
            begin
                send_command(OP_ALIGN);
                send_random_pixels(400);
                send_command(OP_SWAP);
                wait_swap("back_swap", 1'b1);
            end
        join
        scan_frame("back_shown");
    endtask

    task automatic align_and_cancel();
        send_random_pixels(50);
        send_command(OP_ALIGN);
        send_random_pixels(30);
        send_command(OP_SWAP);
        wait_swap("align", 1'b1);
        scan_frame("align");
        send_command(OP_SWAP);
        send_command(OP_ALIGN);
        wait_swap("cancel", 1'b0);
    endtask

    // Five bits then cs_n high, the next full byte is the one written
    task automatic discard_partial_byte();
        rng = xorshift32(rng);
        spi_send(rng[7:0], 5);
        send_random_pixels(1);
        send_command(OP_SWAP);
        wait_swap("partial_byte", 1'b1);
        scan_frame("partial_byte");
    endtask

    initial begin
        logic [16:0] a;
        rst = 1'b1;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        errors = 0;
        rng = SEED;
        model_sel = 1'b0;
        model_addr = '0;
        a = '0;
        repeat (FB_DEPTH) begin
            model[0][a] = 8'hff;
            model[1][a] = 8'hff;
            a = a + 1'b1;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        swap_and_show();
        hold_back_buffer();
        align_and_cancel();
        discard_partial_byte();

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vga_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_spi_top (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           sclk,
    input  wire logic           cs_n,
    input  wire logic           mosi,
    output vga_spi_pkg::color_t vga_r,
    output vga_spi_pkg::color_t vga_g,
    output vga_spi_pkg::color_t vga_b,
    output logic                h_sync,
    output logic                v_sync,
    output logic                swap_done
);
    import vga_spi_pkg::*;

    // SPI to decoder
    byte_t    rx_byte;
    logic     rx_valid;

    // Decoder to frame store
    logic     wr_en;
    fb_addr_t wr_addr;
    byte_t    wr_data;
    logic     swap_req;
    logic     swap_cancel;

    // Display side
    h_count_t h_count;
    v_count_t v_count;
    logic     frame_start;
    fb_addr_t rd_addr;
    byte_t    rd_data;

    spi_byte_receiver u_rx (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    pixel_command_decoder u_dec (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .swap_req(swap_req), .swap_cancel(swap_cancel)
    );

    frame_double_buffer u_fb (
        .clk(clk), .rst(rst), .wr_en(wr_en), .swap_req(swap_req),
        .swap_cancel(swap_cancel), .frame_start(frame_start),
        .wr_addr(wr_addr), .rd_addr(rd_addr), .wr_data(wr_data),
        .rd_data(rd_data), .swap_done(swap_done)
    );

    vga_timing u_timing (
        .clk(clk), .rst(rst), .h_count(h_count), .v_count(v_count),
        .frame_start(frame_start)
    );

    pixel_scanout u_scan (
        .clk(clk), .rst(rst), .h_count(h_count), .v_count(v_count),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .h_sync(h_sync), .v_sync(v_sync)
    );

endmodule

`default_nettype wire

//--- pixel_scanout.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_spi_consts.svh"

module pixel_scanout (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire vga_spi_pkg::h_count_t h_count,
    input  wire vga_spi_pkg::v_count_t v_count,
    output vga_spi_pkg::fb_addr_t      rd_addr,
    input  wire vga_spi_pkg::byte_t    rd_data,
    output vga_spi_pkg::color_t        vga_r,
    output vga_spi_pkg::color_t        vga_g,
    output vga_spi_pkg::color_t        vga_b,
    output logic                       h_sync,
    output logic                       v_sync
);
    import vga_spi_pkg::*;

    localparam h_count_t H_SYNC_END = h_count_t'(`H_SYNC_LEN);
    localparam v_count_t V_SYNC_END = v_count_t'(`V_SYNC_LEN);
    localparam h_count_t H_ACT_LO   = h_count_t'(`H_ACT_START);
    localparam h_count_t H_ACT_HI   = h_count_t'(`H_ACT_END);
    localparam v_count_t V_ACT_LO   = v_count_t'(`V_ACT_START);
    localparam v_count_t V_ACT_HI   = v_count_t'(`V_ACT_END);
    localparam int       PAD_W      = `COLOR_BITS - 2;

    h_count_t h_off;
    v_count_t v_off;
    fb_addr_t frame_x;
    fb_addr_t frame_y;
    logic     h_sync_c;
    logic     v_sync_c;
    logic     active_c;
    logic     h_sync_d;
    logic     v_sync_d;
    logic     active_d;

    assign h_sync_c = (h_count >= H_SYNC_END);
    assign v_sync_c = (v_count >= V_SYNC_END);
    assign active_c = (h_count >= H_ACT_LO) && (h_count < H_ACT_HI) &&
                      (v_count >= V_ACT_LO) && (v_count < V_ACT_HI);

    // Screen position to frame address, each stored pixel covers 2x2
    assign h_off   = h_count - H_ACT_LO;
    assign v_off   = v_count - V_ACT_LO;
    assign frame_x = fb_addr_t'(h_off / h_count_t'(`RES_DIV));
    assign frame_y = fb_addr_t'(v_off / v_count_t'(`RES_DIV));
    assign rd_addr = active_c ? frame_x + frame_y * fb_addr_t'(`RES_X) : '0;

    // ==================================================
    // Stage 1 waits out the RAM read, stage 2 drives the pins
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_sync_d <= 1'b1;
            v_sync_d <= 1'b1;
            active_d <= 1'b0;
            h_sync   <= 1'b1;
            v_sync   <= 1'b1;
            vga_r    <= '0;
            vga_g    <= '0;
            vga_b    <= '0;
        end else begin
            h_sync_d <= h_sync_c;
            v_sync_d <= v_sync_c;
            active_d <= active_c;
            h_sync   <= h_sync_d;
            v_sync   <= v_sync_d;
            // 00RRGGBB, each field becomes the top bits of its channel
            vga_r    <= active_d ? {rd_data[5:4], {PAD_W{1'b0}}} : '0;
            vga_g    <= active_d ? {rd_data[3:2], {PAD_W{1'b0}}} : '0;
            vga_b    <= active_d ? {rd_data[1:0], {PAD_W{1'b0}}} : '0;
        end
    end

endmodule

`default_nettype wire

//--- vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_spi_consts.svh"

module vga_timing (
    input  wire logic            clk,
    input  wire logic            rst,
    output vga_spi_pkg::h_count_t h_count,
    output vga_spi_pkg::v_count_t v_count,
    output logic                 frame_start
);
    import vga_spi_pkg::*;

    localparam int       DIV_W  = $clog2(`PIX_DIV);
    localparam h_count_t H_LAST = h_count_t'(`H_TOTAL - 1);
    localparam v_count_t V_LAST = v_count_t'(`V_TOTAL - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             pix_tick;

    // Counters step on the last clk of each pixel period
    assign pix_tick    = (div_cnt == DIV_W'(`PIX_DIV - 1));
    assign frame_start = (div_cnt == '0) && (h_count == '0) && (v_count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            h_count <= '0;
            v_count <= '0;
        end else if (pix_tick) begin
            div_cnt <= '0;
            if (h_count == H_LAST) begin
                h_count <= '0;
                if (v_count == V_LAST) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) (h_count <= H_LAST) && (v_count <= V_LAST))
        else $error("raster counter out of range");

endmodule

`default_nettype wire

//--- frame_double_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_double_buffer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_en,
    input  wire logic                  swap_req,
    input  wire logic                  swap_cancel,
    input  wire logic                  frame_start,
    input  wire vga_spi_pkg::fb_addr_t wr_addr,
    input  wire vga_spi_pkg::fb_addr_t rd_addr,
    input  wire vga_spi_pkg::byte_t    wr_data,
    output vga_spi_pkg::byte_t         rd_data,
    output logic                       swap_done
);
    import vga_spi_pkg::*;

    // bank_sel names the back bank, the other one is on screen
    logic  bank_sel;
    logic  swap_pending;
    logic  wr_en_0;
    logic  wr_en_1;
    byte_t rd_data_0;
    byte_t rd_data_1;

    assign wr_en_0 = wr_en && !bank_sel;
    assign wr_en_1 = wr_en && bank_sel;
    assign rd_data = bank_sel ? rd_data_0 : rd_data_1;

    // Swap waits for the top of the next frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_sel     <= 1'b0;
            swap_pending <= 1'b0;
            swap_done    <= 1'b0;
        end else begin
            swap_done <= 1'b0;
            if (frame_start && swap_pending) begin
                bank_sel     <= ~bank_sel;
                swap_pending <= 1'b0;
                swap_done    <= 1'b1;
            end else if (swap_cancel) begin
                swap_pending <= 1'b0;
            end else if (swap_req) begin
                swap_pending <= 1'b1;
            end
        end
    end

    frame_ram u_bank0 (
        .clk     (clk),
        .wr_en   (wr_en_0),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data_0)
    );

    frame_ram u_bank1 (
        .clk     (clk),
        .wr_en   (wr_en_1),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data_1)
    );

    // Buffers only trade places on a single-cycle frame boundary from vga_timing
    assert property (@(posedge clk) disable iff (rst)
                     swap_done |-> $past(frame_start) && !frame_start)
        else $error("swap_done away from a single-cycle frame start");

endmodule

`default_nettype wire

//--- frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_spi_consts.svh"

module frame_ram (
    input  wire logic                  clk,
    input  wire logic                  wr_en,
    input  wire vga_spi_pkg::fb_addr_t wr_addr,
    input  wire vga_spi_pkg::byte_t    wr_data,
    input  wire vga_spi_pkg::fb_addr_t rd_addr,
    output vga_spi_pkg::byte_t         rd_data
);
    import vga_spi_pkg::*;

    byte_t mem [0:`FB_DEPTH-1];

    // Simple dual port, registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- pixel_command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_spi_consts.svh"

module pixel_command_decoder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               rx_valid,
    input  wire vga_spi_pkg::byte_t rx_byte,
    output logic                    wr_en,
    output vga_spi_pkg::fb_addr_t   wr_addr,
    output vga_spi_pkg::byte_t      wr_data,
    output logic                    swap_req,
    output logic                    swap_cancel
);
    import vga_spi_pkg::*;

    localparam fb_addr_t LAST_ADDR = fb_addr_t'(`FB_DEPTH - 1);

    fb_addr_t next_addr;
    logic     is_cmd;
    cmd_op_t  cmd_op;

    assign is_cmd = rx_byte[7];
    assign cmd_op = cmd_op_t'(rx_byte[6:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en       <= 1'b0;
            swap_req    <= 1'b0;
            swap_cancel <= 1'b0;
            next_addr   <= '0;
        end else begin
            wr_en       <= 1'b0;
            swap_req    <= 1'b0;
            swap_cancel <= 1'b0;
            if (rx_valid) begin
                if (!is_cmd) begin
                    // Write here, then step on
                    wr_en <= 1'b1;
                    if (next_addr == LAST_ADDR) begin
                        next_addr <= '0;
                    end else begin
                        next_addr <= next_addr + 1'b1;
                    end
                end else begin
                    case (cmd_op)
                        CMD_SWAP: swap_req <= 1'b1;
                        // Align, and any unknown opcode
                        default: begin
                            next_addr   <= '0;
                            swap_cancel <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && !is_cmd) begin
            wr_addr <= next_addr;
            wr_data <= rx_byte;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(wr_en && swap_req))
        else $error("pixel write and swap request in the same cycle");

endmodule

`default_nettype wire

//--- spi_byte_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_receiver (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          sclk,
    input  wire logic          cs_n,
    input  wire logic          mosi,
    output vga_spi_pkg::byte_t rx_byte,
    output logic               rx_valid
);
    import vga_spi_pkg::*;

    localparam int BIT_W = $clog2($bits(byte_t));

    logic [6:0]       shift_reg;
    logic [BIT_W-1:0] bit_cnt;
    logic             last_bit;
    byte_t            captured;
    logic             rx_toggle;

    logic [2:0] toggle_sync;
    logic       toggle_edge;
    byte_t      data_sync1;
    byte_t      data_sync2;

    assign last_bit    = (bit_cnt == BIT_W'($bits(byte_t) - 1));
    assign toggle_edge = toggle_sync[1] ^ toggle_sync[2];

    // ==================================================
    // SCLK domain
    // ==================================================

    // Chip select high throws away a partial byte
    always_ff @(posedge sclk or posedge rst or posedge cs_n) begin
        if (rst || cs_n) begin
            shift_reg <= '0;
            bit_cnt   <= '0;
        end else begin
            shift_reg <= {shift_reg[5:0], mosi};
            bit_cnt   <= bit_cnt + 1'b1;
        end
    end

    // Toggle survives cs_n so the clk side sees one flip per byte
    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            rx_toggle <= 1'b0;
        end else if (last_bit) begin
            rx_toggle <= ~rx_toggle;
        end
    end

    always_ff @(posedge sclk) begin
        if (last_bit) begin
            captured <= {shift_reg, mosi};
        end
    end

    // ==================================================
    // CLK domain
    // ==================================================

    // Byte is stable for the whole time the toggle takes to cross
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            toggle_sync <= '0;
            rx_valid    <= 1'b0;
        end else begin
            toggle_sync <= {toggle_sync[1:0], rx_toggle};
            rx_valid    <= toggle_edge;
        end
    end

    always_ff @(posedge clk) begin
        data_sync1 <= captured;
        data_sync2 <= data_sync1;
        if (toggle_edge) begin
            rx_byte <= data_sync2;
        end
    end

endmodule

`default_nettype wire

//--- vga_spi_pkg.sv
`default_nettype none

`include "vga_spi_consts.svh"

package vga_spi_pkg;

    // One SPI byte, also one stored pixel (00RRGGBB)
    typedef logic [7:0] byte_t;

    typedef logic [$clog2(`FB_DEPTH)-1:0] fb_addr_t;

    typedef logic [$clog2(`H_TOTAL)-1:0] h_count_t;
    typedef logic [$clog2(`V_TOTAL)-1:0] v_count_t;

    typedef logic [`COLOR_BITS-1:0] color_t;

    // Low seven bits of a command byte
    typedef enum logic [6:0] {
        CMD_ALIGN = 7'h00,
        CMD_SWAP  = 7'h01
    } cmd_op_t;

endpackage

`default_nettype wire

//--- vga_spi_consts.svh
`ifndef VGA_SPI_CONSTS_SVH
`define VGA_SPI_CONSTS_SVH

// Frame store geometry
`define RES_X           320
`define RES_Y           240
`define RES_DIV         2
`define FB_DEPTH        (`RES_X * `RES_Y)

// 640x480 VGA timing in pixel ticks, sync pulses at the start of each period
`define H_TOTAL         800
`define V_TOTAL         525
`define H_SYNC_LEN      96
`define V_SYNC_LEN      2
`define H_ACT_START     144
`define H_ACT_END       784
`define V_ACT_START     35
`define V_ACT_END       515

// System clocks per pixel tick
`define PIX_DIV         2

// Width of each DAC channel
`define COLOR_BITS      4

`endif
